// File: rtl/dp_consts.svh
//################################################
// Dispatch stage constants
// Sizes shared by the dispatch RTL and the testbench
//################################################

`ifndef DP_CONSTS_SVH
`define DP_CONSTS_SVH

// Uops looked at per cycle
// Issue logic is written for exactly two
`define DP_NUM_UOP      2

// ROB entries presented to dispatch, oldest at index 0
`define DP_ROB_DEPTH    8
`define DP_ROB_IDX_W    3

// VRF read ports shared by both uops
`define DP_NUM_VRF_RD   4

// Vector register width and register index width
`define DP_VLEN         64
`define DP_VREG_IDX_W   5

`define DP_XLEN         32

`endif

// File: rtl/dp_pkg.sv
//################################################
// Dispatch types
// Uop, ROB entry and RS/ROB payload formats
//################################################

`include "dp_consts.svh"

package dp_pkg;

    typedef logic [`DP_VREG_IDX_W-1:0] vreg_idx_t;
    typedef logic [`DP_VLEN-1:0]       vdata_t;
    typedef logic [`DP_XLEN-1:0]       xdata_t;
    typedef logic [`DP_ROB_IDX_W-1:0]  rob_idx_t;

    typedef enum logic {
        EXE_ALU = 1'b0,
        EXE_MUL = 1'b1
    } exe_unit_e;

    // VVV reads vs1, vs2, vd; VV reads vs1, vs2; VX reads vs2 only
    typedef enum logic [1:0] {
        VVV = 2'd0,
        VV  = 2'd1,
        VX  = 2'd2
    } uop_class_e;

    typedef struct packed {
        exe_unit_e  exe_unit;
        uop_class_e uop_class;
        logic [5:0] funct6;
        vreg_idx_t  vd_index;
        logic       vd_valid;
        vreg_idx_t  vs1_index;
        vreg_idx_t  vs2_index;
        xdata_t     rs1_data;
    } uop_t;

    typedef struct packed {
        logic      valid;
        // Result already written back
        logic      w_valid;
        vreg_idx_t w_index;
        vdata_t    w_data;
    } rob_entry_t;

    typedef struct packed {
        vdata_t vs1_data;
        vdata_t vs2_data;
        vdata_t vd_data;
    } operand_t;

    // Shared by the ALU and MUL stations
    typedef struct packed {
        rob_idx_t   rob_tag;
        logic [5:0] funct6;
        uop_class_e uop_class;
        vdata_t     vs1_data;
        vdata_t     vs2_data;
        vdata_t     vd_data;
        xdata_t     rs1_data;
    } rs_uop_t;

    typedef struct packed {
        vreg_idx_t w_index;
        logic      w_valid;
        exe_unit_e exe_unit;
    } dp2rob_t;

endpackage

// File: rtl/dp_lane_if.sv
//################################################
// Dispatch lane bundle
// One uop with its VRF read data and resolved operands
//################################################

`timescale 1ns/1ps

interface dp_lane_if
    import dp_pkg::*;
();

    uop_t     uop;
    logic     uop_valid;

    // VRF read data, same cycle as the read index
    vdata_t   vs1_rd;
    vdata_t   vs2_rd;
    vdata_t   vd_rd;

    // After ROB forwarding
    operand_t opnd;
    logic     rob_hazard;

    modport alloc (
        input  uop,
        output vs1_rd, vs2_rd, vd_rd
    );

    modport lane (
        input  uop, uop_valid, vs1_rd, vs2_rd, vd_rd,
        output opnd, rob_hazard
    );

    modport ctrl (
        input  uop, uop_valid, rob_hazard
    );

endinterface

// File: rtl/dp_vrf_port_alloc.sv
//################################################
// VRF read port allocator
// Packs both uops' reads onto the shared ports,
// flags the structure hazard and returns the data
//################################################

`timescale 1ns/1ps
`include "dp_consts.svh"

module dp_vrf_port_alloc
    import dp_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    dp_lane_if.alloc                          lane0,
    dp_lane_if.alloc                          lane1,
    output vreg_idx_t [`DP_NUM_VRF_RD-1:0]    vrf_rd_index,
    input  vdata_t    [`DP_NUM_VRF_RD-1:0]    vrf_rd_data,
    output logic                              strct_hazard
);

    logic [1:0]      cnt0;
    logic [1:0]      cnt1;
    logic [2:0]      cnt_total;
    // Element order is the port order: vs2, vs1, vd
    vreg_idx_t [2:0] src0;
    vreg_idx_t [2:0] src1;
    vdata_t    [2:0] rd0;
    vdata_t    [2:0] rd1;

    function automatic logic [1:0] read_count(uop_class_e cls);
        case (cls)
            VVV:     return 2'd3;
            VV:      return 2'd2;
            default: return 2'd1;
        endcase
    endfunction

    assign cnt0      = read_count(lane0.uop.uop_class);
    assign cnt1      = read_count(lane1.uop.uop_class);
    assign cnt_total = {1'b0, cnt0} + {1'b0, cnt1};

    assign strct_hazard = (cnt_total > 3'(`DP_NUM_VRF_RD));

    assign src0 = {lane0.uop.vd_index, lane0.uop.vs1_index, lane0.uop.vs2_index};
    assign src1 = {lane1.uop.vd_index, lane1.uop.vs1_index, lane1.uop.vs2_index};

    // uop0 from port 0, uop1 right behind it, idle ports read v0
    always_comb begin
        for (int p = 0; p < `DP_NUM_VRF_RD; p++) begin
            vrf_rd_index[p] = '0;
            if (p < int'(cnt0)) begin
                vrf_rd_index[p] = src0[p];
            end else if (!strct_hazard && (p - int'(cnt0)) < int'(cnt1)) begin
                vrf_rd_index[p] = src1[p - int'(cnt0)];
            end
        end
    end

    // Return data per source, zero for a source the class does not read
    always_comb begin
        logic [1:0] p1;
        for (int k = 0; k < 3; k++) begin
            p1     = cnt0 + 2'(k);
            rd0[k] = (k < int'(cnt0)) ? vrf_rd_data[k] : '0;
            rd1[k] = (!strct_hazard && k < int'(cnt1)) ? vrf_rd_data[p1] : '0;
        end
    end

    assign lane0.vs2_rd = rd0[0];
    assign lane0.vs1_rd = rd0[1];
    assign lane0.vd_rd  = rd0[2];
    assign lane1.vs2_rd = rd1[0];
    assign lane1.vs1_rd = rd1[1];
    assign lane1.vd_rd  = rd1[2];

    // Port count of uop0 is only defined for its three classes
    a_uop0_fits: assert property (@(posedge clk) disable iff (reset)
        lane0.uop.uop_class inside {VVV, VV, VX});

endmodule

// File: rtl/dp_operand_lane.sv
//################################################
// Operand lane
// ROB RAW check and ROB-over-VRF forwarding
// for the sources of one uop
//################################################

`timescale 1ns/1ps
`include "dp_consts.svh"

module dp_operand_lane
    import dp_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    dp_lane_if.lane                         lane,
    input  rob_entry_t [`DP_ROB_DEPTH-1:0]  rob_entry
);

    // Source order: vs2, vs1, vd
    logic       [2:0] src_used;
    vreg_idx_t  [2:0] src_index;
    vdata_t     [2:0] vrf_data;
    rob_entry_t [2:0] src_match;
    vdata_t     [2:0] src_data;
    logic       [2:0] src_pending;

    // Youngest valid ROB entry that writes idx
    // Clear valid in the result means no match
    function automatic rob_entry_t youngest_match(
        vreg_idx_t                      idx,
        rob_entry_t [`DP_ROB_DEPTH-1:0] ent
    );
        rob_entry_t m;
        m = '0;
        for (int i = 0; i < `DP_ROB_DEPTH; i++) begin
            if (ent[i].valid && ent[i].w_index == idx) begin
                m = ent[i];
            end
        end
        return m;
    endfunction

    assign src_used[0] = 1'b1;
    assign src_used[1] = lane.uop.uop_class inside {VVV, VV};
    assign src_used[2] = (lane.uop.uop_class == VVV);

    assign src_index = {lane.uop.vd_index, lane.uop.vs1_index, lane.uop.vs2_index};
    assign vrf_data  = {lane.vd_rd, lane.vs1_rd, lane.vs2_rd};

    always_comb begin
        for (int s = 0; s < 3; s++) begin
            src_match[s]   = youngest_match(src_index[s], rob_entry);
            // Producer still in flight
            src_pending[s] = src_used[s] && src_match[s].valid && !src_match[s].w_valid;
            if (src_used[s] && src_match[s].valid && src_match[s].w_valid) begin
                src_data[s] = src_match[s].w_data;
            end else begin
                src_data[s] = vrf_data[s];
            end
        end
    end

    assign lane.opnd.vs2_data = src_data[0];
    assign lane.opnd.vs1_data = src_data[1];
    assign lane.opnd.vd_data  = src_data[2];
    assign lane.rob_hazard    = |src_pending;

    a_hazard_known: assert property (@(posedge clk) disable iff (reset)
        lane.uop_valid |-> !$isunknown(lane.rob_hazard));

endmodule

// File: rtl/dp_issue_ctrl.sv
//################################################
// Dispatch issue control
// In-order issue of up to two uops to the RSs
// and the ROB
//################################################

`timescale 1ns/1ps
`include "dp_consts.svh"

module dp_issue_ctrl
    import dp_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    dp_lane_if.ctrl                 lane0,
    dp_lane_if.ctrl                 lane1,
    input  logic                    strct_hazard,
    input  logic [`DP_NUM_UOP-1:0]  alu_ready,
    input  logic [`DP_NUM_UOP-1:0]  mul_ready,
    input  logic [`DP_NUM_UOP-1:0]  rob_ready,
    output logic [`DP_NUM_UOP-1:0]  uop_ready,
    output logic [`DP_NUM_UOP-1:0]  alu_valid,
    output logic [`DP_NUM_UOP-1:0]  mul_valid,
    output logic [`DP_NUM_UOP-1:0]  rob_valid
);

    exe_unit_e              unit [`DP_NUM_UOP];
    logic [`DP_NUM_UOP-1:0] rs_ready;
    logic [`DP_NUM_UOP-1:0] issue;
    logic                   raw_vs2;
    logic                   raw_vs1;
    logic                   raw_vd;
    logic                   raw_uop;

    assign unit[0] = lane0.uop.exe_unit;
    assign unit[1] = lane1.uop.exe_unit;

    // Ready of the station each lane targets
    always_comb begin
        for (int i = 0; i < `DP_NUM_UOP; i++) begin
            rs_ready[i] = (unit[i] == EXE_MUL) ? mul_ready[i] : alu_ready[i];
        end
    end

    // uop1 reads what uop0 is about to write
    assign raw_vs2 = (lane1.uop.vs2_index == lane0.uop.vd_index);
    assign raw_vs1 = (lane1.uop.uop_class inside {VVV, VV})
                     && (lane1.uop.vs1_index == lane0.uop.vd_index);
    assign raw_vd  = (lane1.uop.uop_class == VVV)
                     && (lane1.uop.vd_index == lane0.uop.vd_index);
    assign raw_uop = lane0.uop.vd_valid && (raw_vs2 || raw_vs1 || raw_vd);

    assign issue[0] = lane0.uop_valid && !lane0.rob_hazard && rs_ready[0] && rob_ready[0];

    // uop1 only goes out behind uop0
    assign issue[1] = issue[0] && lane1.uop_valid && !lane1.rob_hazard && !strct_hazard
                      && !raw_uop && rs_ready[1] && rob_ready[1];

    always_comb begin
        for (int i = 0; i < `DP_NUM_UOP; i++) begin
            alu_valid[i] = issue[i] && (unit[i] == EXE_ALU);
            mul_valid[i] = issue[i] && (unit[i] == EXE_MUL);
        end
    end

    assign uop_ready = issue;
    assign rob_valid = issue;

    a_in_order: assert property (@(posedge clk) disable iff (reset)
        uop_ready[1] |-> uop_ready[0]);

    // One station per uop
    a_one_unit: assert property (@(posedge clk) disable iff (reset)
        (alu_valid & mul_valid) == '0);

endmodule

// File: rtl/rvv_dispatch.sv
//################################################
// Two-wide vector dispatch stage
// ROB/uop RAW checks, VRF port sharing, operand
// forwarding and in-order issue to ALU/MUL RS and ROB
//################################################

`timescale 1ns/1ps
`include "dp_consts.svh"

module rvv_dispatch
    import dp_pkg::*;
(
    input  logic                                           clk,
    input  logic                                           reset,
    // Uop queue
    input  logic       [`DP_NUM_UOP-1:0]                   uop_valid,
    input  uop_t       [`DP_NUM_UOP-1:0]                   uop,
    output logic       [`DP_NUM_UOP-1:0]                   uop_ready,
    // ALU RS
    output logic       [`DP_NUM_UOP-1:0]                   alu_valid,
    output rs_uop_t    [`DP_NUM_UOP-1:0]                   alu_rs,
    input  logic       [`DP_NUM_UOP-1:0]                   alu_ready,
    // MUL RS
    output logic       [`DP_NUM_UOP-1:0]                   mul_valid,
    output rs_uop_t    [`DP_NUM_UOP-1:0]                   mul_rs,
    input  logic       [`DP_NUM_UOP-1:0]                   mul_ready,
    // ROB
    output logic       [`DP_NUM_UOP-1:0]                   rob_valid,
    output dp2rob_t    [`DP_NUM_UOP-1:0]                   rob_uop,
    input  logic       [`DP_NUM_UOP-1:0]                   rob_ready,
    input  logic       [`DP_ROB_IDX_W-1:0]                 rob_index,
    // VRF read, data comes back in the same cycle
    output logic [`DP_NUM_VRF_RD-1:0][`DP_VREG_IDX_W-1:0]  vrf_rd_index,
    input  logic [`DP_NUM_VRF_RD-1:0][`DP_VLEN-1:0]        vrf_rd_data,
    input  rob_entry_t [`DP_ROB_DEPTH-1:0]                 rob_entry
);

    logic                       strct_hazard;
    rs_uop_t [`DP_NUM_UOP-1:0]  rs_pkt;

    dp_lane_if lane_bus [`DP_NUM_UOP] ();

    dp_vrf_port_alloc i_vrf_port_alloc (
        .clk          (clk),
        .reset        (reset),
        .lane0        (lane_bus[0]),
        .lane1        (lane_bus[1]),
        .vrf_rd_index (vrf_rd_index),
        .vrf_rd_data  (vrf_rd_data),
        .strct_hazard (strct_hazard)
    );

    genvar i;
    generate
        for (i = 0; i < `DP_NUM_UOP; i++) begin : gen_lane
            assign lane_bus[i].uop       = uop[i];
            assign lane_bus[i].uop_valid = uop_valid[i];

            dp_operand_lane i_operand_lane (
                .clk       (clk),
                .reset     (reset),
                .lane      (lane_bus[i]),
                .rob_entry (rob_entry)
            );

            // ROB allocates consecutive entries for the two lanes
            assign rs_pkt[i].rob_tag   = rob_index + rob_idx_t'(i);
            assign rs_pkt[i].funct6    = uop[i].funct6;
            assign rs_pkt[i].uop_class = uop[i].uop_class;
            assign rs_pkt[i].vs1_data  = lane_bus[i].opnd.vs1_data;
            assign rs_pkt[i].vs2_data  = lane_bus[i].opnd.vs2_data;
            assign rs_pkt[i].vd_data   = lane_bus[i].opnd.vd_data;
            assign rs_pkt[i].rs1_data  = uop[i].rs1_data;

            assign alu_rs[i] = rs_pkt[i];
            assign mul_rs[i] = rs_pkt[i];

            assign rob_uop[i].w_index  = uop[i].vd_index;
            assign rob_uop[i].w_valid  = uop[i].vd_valid;
            assign rob_uop[i].exe_unit = uop[i].exe_unit;
        end
    endgenerate

    dp_issue_ctrl i_issue_ctrl (
        .clk          (clk),
        .reset        (reset),
        .lane0        (lane_bus[0]),
        .lane1        (lane_bus[1]),
        .strct_hazard (strct_hazard),
        .alu_ready    (alu_ready),
        .mul_ready    (mul_ready),
        .rob_ready    (rob_ready),
        .uop_ready    (uop_ready),
        .alu_valid    (alu_valid),
        .mul_valid    (mul_valid),
        .rob_valid    (rob_valid)
    );

endmodule

// File: test/tb_dispatch_model.svh
//##################################################
// Dispatch reference model
// Expected VRF indices, issue decisions and RS
// payloads computed from the stage's rules
//##################################################

`ifndef TB_DISPATCH_MODEL_SVH
`define TB_DISPATCH_MODEL_SVH

typedef uop_t       [`DP_NUM_UOP-1:0]    uop_vec_t;
typedef rob_entry_t [`DP_ROB_DEPTH-1:0]  rob_vec_t;
typedef vreg_idx_t  [`DP_NUM_VRF_RD-1:0] vrf_idx_vec_t;
typedef vdata_t     [`DP_NUM_VRF_RD-1:0] vrf_data_vec_t;

// Source numbering: 0 is vs2, 1 is vs1, 2 is vd
function automatic logic src_used(uop_class_e cls, int s);
    case (s)
        0:       return 1'b1;
        1:       return (cls == VVV) || (cls == VV);
        default: return (cls == VVV);
    endcase
endfunction

function automatic int src_count(uop_class_e cls);
    int n;
    n = 0;
    for (int s = 0; s < 3; s++) begin
        if (src_used(cls, s)) begin
            n++;
        end
    end
    return n;
endfunction

function automatic vreg_idx_t src_index(uop_t u, int s);
    case (s)
        0:       return u.vs2_index;
        1:       return u.vs1_index;
        default: return u.vd_index;
    endcase
endfunction

// Search from the youngest entry down, -1 when nothing writes idx
function automatic int youngest_writer(vreg_idx_t idx, rob_vec_t rob);
    for (int k = `DP_ROB_DEPTH - 1; k >= 0; k--) begin
        if (rob[k].valid && rob[k].w_index == idx) begin
            return k;
        end
    end
    return -1;
endfunction

function automatic logic model_hazard(uop_t u, rob_vec_t rob);
    int k;
    for (int s = 0; s < 3; s++) begin
        if (src_used(u.uop_class, s)) begin
            k = youngest_writer(src_index(u, s), rob);
            if (k >= 0 && !rob[k].w_valid) begin
                return 1'b1;
            end
        end
    end
    return 1'b0;
endfunction

function automatic logic fits_ports(uop_vec_t u);
    return (src_count(u[0].uop_class) + src_count(u[1].uop_class)) <= `DP_NUM_VRF_RD;
endfunction

function automatic vrf_idx_vec_t model_vrf_index(uop_vec_t u);
    vrf_idx_vec_t r;
    int           p;
    r = '0;
    p = 0;
    for (int s = 0; s < src_count(u[0].uop_class); s++) begin
        r[p] = src_index(u[0], s);
        p++;
    end
    if (fits_ports(u)) begin
        for (int s = 0; s < src_count(u[1].uop_class); s++) begin
            r[p] = src_index(u[1], s);
            p++;
        end
    end
    return r;
endfunction

function automatic logic [1:0] model_issue(uop_vec_t u, logic [1:0] valid, rob_vec_t rob,
                                           logic [1:0] alu_r, logic [1:0] mul_r,
                                           logic [1:0] rob_r);
    logic [1:0] iss;
    logic [1:0] rs_r;
    logic       raw;
    for (int i = 0; i < 2; i++) begin
        rs_r[i] = (u[i].exe_unit == EXE_MUL) ? mul_r[i] : alu_r[i];
    end
    raw = 1'b0;
    for (int s = 0; s < 3; s++) begin
        if (src_used(u[1].uop_class, s) && u[0].vd_valid
            && src_index(u[1], s) == u[0].vd_index) begin
            raw = 1'b1;
        end
    end
    iss[0] = valid[0] && !model_hazard(u[0], rob) && rs_r[0] && rob_r[0];
    iss[1] = iss[0] && valid[1] && !model_hazard(u[1], rob) && fits_ports(u) && !raw
             && rs_r[1] && rob_r[1];
    return iss;
endfunction

// Unread sources carry no defined data, so they are cleared before a compare
function automatic rs_uop_t keep_used(rs_uop_t p, uop_class_e cls);
    if (!src_used(cls, 1)) begin
        p.vs1_data = '0;
    end
    if (!src_used(cls, 2)) begin
        p.vd_data = '0;
    end
    return p;
endfunction

function automatic rs_uop_t model_rs(uop_t u, int lane, int first_port, rob_idx_t base,
                                     vrf_data_vec_t vrf, rob_vec_t rob);
    rs_uop_t e;
    vdata_t  d [3];
    int      k;
    for (int s = 0; s < 3; s++) begin
        d[s] = '0;
        if (src_used(u.uop_class, s)) begin
            k = youngest_writer(src_index(u, s), rob);
            if (k >= 0 && rob[k].w_valid) begin
                d[s] = rob[k].w_data;
            end else begin
                d[s] = vrf[first_port + s];
            end
        end
    end
    e.rob_tag   = rob_idx_t'(int'(base) + lane);
    e.funct6    = u.funct6;
    e.uop_class = u.uop_class;
    e.vs2_data  = d[0];
    e.vs1_data  = d[1];
    e.vd_data   = d[2];
    e.rs1_data  = u.rs1_data;
    return e;
endfunction

`endif

// File: test/tb_dispatch.sv
//##################################################
// Dispatch stage testbench
// Random uops, ROB state and readies each cycle,
// checked against the reference model
//##################################################

`timescale 1ns/1ps
`include "dp_consts.svh"

module tb_dispatch
    import dp_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_TESTS    = 2000;

    `include "tb_dispatch_model.svh"

    logic              clk;
    logic              reset;
    logic [1:0]        uop_valid;
    uop_vec_t          uop;
    logic [1:0]        uop_ready;
    logic [1:0]        alu_valid;
    rs_uop_t [1:0]     alu_rs;
    logic [1:0]        alu_ready;
    logic [1:0]        mul_valid;
    rs_uop_t [1:0]     mul_rs;
    logic [1:0]        mul_ready;
    logic [1:0]        rob_valid;
    dp2rob_t [1:0]     rob_uop;
    logic [1:0]        rob_ready;
    rob_idx_t          rob_index;
    vrf_idx_vec_t      vrf_rd_index;
    vrf_data_vec_t     vrf_rd_data;
    rob_vec_t          rob_entry;

    logic [31:0]       rng_state = 32'd7316;
    int                rs_errors;
    int                rob_errors;
    int                bit_errors;

    rvv_dispatch i_rvv_dispatch (
        .clk          (clk),
        .reset        (reset),
        .uop_valid    (uop_valid),
        .uop          (uop),
        .uop_ready    (uop_ready),
        .alu_valid    (alu_valid),
        .alu_rs       (alu_rs),
        .alu_ready    (alu_ready),
        .mul_valid    (mul_valid),
        .mul_rs       (mul_rs),
        .mul_ready    (mul_ready),
        .rob_valid    (rob_valid),
        .rob_uop      (rob_uop),
        .rob_ready    (rob_ready),
        .rob_index    (rob_index),
        .vrf_rd_index (vrf_rd_index),
        .vrf_rd_data  (vrf_rd_data),
        .rob_entry    (rob_entry)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_bits(string name, logic [31:0] act, logic [31:0] exp);
        if (act !== exp) begin
            bit_errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_rs(string name, rs_uop_t act, rs_uop_t exp);
        if (act !== exp) begin
            rs_errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_rob(string name, dp2rob_t act, dp2rob_t exp);
        if (act !== exp) begin
            rob_errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic init_inputs();
        clk         = 1'b0;
        reset       = 1'b1;
        uop_valid   = '0;
        uop         = '0;
        alu_ready   = '0;
        mul_ready   = '0;
        rob_ready   = '0;
        rob_index   = '0;
        vrf_rd_data = '0;
        rob_entry   = '0;
    endtask

    // Register indices stay in 0..7 so that hazards show up often
    task automatic drive_random();
        logic [31:0] r;
        for (int i = 0; i < 2; i++) begin
            r = xorshift32();
            uop[i].exe_unit  = exe_unit_e'(r[0]);
            uop[i].uop_class = uop_class_e'((r[2:1] == 2'd3) ? 2'd0 : r[2:1]);
            uop[i].funct6    = r[8:3];
            uop[i].vd_index  = {2'b00, r[11:9]};
            uop[i].vd_valid  = r[12];
            uop[i].vs1_index = {2'b00, r[15:13]};
            uop[i].vs2_index = {2'b00, r[18:16]};
            uop_valid[i]     = (r[21:19] != 3'd0);
            alu_ready[i]     = (r[24:22] != 3'd0);
            mul_ready[i]     = (r[27:25] != 3'd0);
            rob_ready[i]     = (r[30:28] != 3'd0);
            uop[i].rs1_data  = xorshift32();
        end
        for (int k = 0; k < `DP_ROB_DEPTH; k++) begin
            r = xorshift32();
            rob_entry[k].valid   = r[0];
            rob_entry[k].w_valid = (r[2:1] != 2'd0);
            rob_entry[k].w_index = {2'b00, r[5:3]};
            rob_entry[k].w_data  = {xorshift32(), xorshift32()};
        end
        for (int p = 0; p < `DP_NUM_VRF_RD; p++) begin
            vrf_rd_data[p] = {xorshift32(), xorshift32()};
        end
        r = xorshift32();
        rob_index = r[2:0];
    endtask

    task automatic check_reset_outputs();
        check_bits("uop_ready", 32'(uop_ready), 32'd0);
        check_bits("alu_valid", 32'(alu_valid), 32'd0);
        check_bits("mul_valid", 32'(mul_valid), 32'd0);
        check_bits("rob_valid", 32'(rob_valid), 32'd0);
    endtask

    task automatic check_cycle();
        logic [1:0] exp_issue;
        logic [1:0] exp_alu;
        logic [1:0] exp_mul;
        rs_uop_t    exp_rs;
        dp2rob_t    exp_rob;
        int         first;
        exp_issue = model_issue(uop, uop_valid, rob_entry, alu_ready, mul_ready, rob_ready);
        for (int i = 0; i < 2; i++) begin
            exp_alu[i] = exp_issue[i] && (uop[i].exe_unit == EXE_ALU);
            exp_mul[i] = exp_issue[i] && (uop[i].exe_unit == EXE_MUL);
        end
        check_bits("vrf_rd_index", 32'(vrf_rd_index), 32'(model_vrf_index(uop)));
        check_bits("uop_ready", 32'(uop_ready), 32'(exp_issue));
        check_bits("rob_valid", 32'(rob_valid), 32'(exp_issue));
        check_bits("alu_valid", 32'(alu_valid), 32'(exp_alu));
        check_bits("mul_valid", 32'(mul_valid), 32'(exp_mul));
        for (int i = 0; i < 2; i++) begin
            if (exp_issue[i]) begin
                // uop1 reads right behind uop0's ports
                first  = (i == 0) ? 0 : src_count(uop[0].uop_class);
                exp_rs = model_rs(uop[i], i, first, rob_index, vrf_rd_data, rob_entry);
                if (uop[i].exe_unit == EXE_ALU) begin
                    check_rs($sformatf("alu_rs[%0d]", i),
                             keep_used(alu_rs[i], uop[i].uop_class), exp_rs);
                end else begin
                    check_rs($sformatf("mul_rs[%0d]", i),
                             keep_used(mul_rs[i], uop[i].uop_class), exp_rs);
                end
                exp_rob.w_index  = uop[i].vd_index;
                exp_rob.w_valid  = uop[i].vd_valid;
                exp_rob.exe_unit = uop[i].exe_unit;
                check_rob($sformatf("rob_uop[%0d]", i), rob_uop[i], exp_rob);
            end
        end
    endtask

    initial begin : watchdog
        #((NUM_TESTS + RESET_CYCLES) * CLK_PERIOD * 2);
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        rs_errors  = 0;
        rob_errors = 0;
        bit_errors = 0;
        init_inputs();
        // Checks sit just before each rising edge
        for (int c = 0; c < RESET_CYCLES; c++) begin
            #(CLK_PERIOD / 2 - 10);
            check_reset_outputs();
            @(negedge clk);
        end
        reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            drive_random();
            #(CLK_PERIOD / 2 - 10);
            check_cycle();
            @(negedge clk);
        end
        $display("Error counts: rs payload %0d, rob payload %0d, control %0d",
                 rs_errors, rob_errors, bit_errors);
        if (rs_errors + rob_errors + bit_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+rtl
+incdir+test
rtl/dp_pkg.sv
rtl/dp_lane_if.sv
rtl/dp_vrf_port_alloc.sv
rtl/dp_operand_lane.sv
rtl/dp_issue_ctrl.sv
rtl/rvv_dispatch.sv
test/tb_dispatch.sv

// File: Makefile
# Verilator build and run for the dispatch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_dispatch
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
